// File: design/ras_pkg.sv
// Two threads of 16 entries each; return addresses are 47-bit bundle/slot values
`default_nettype none

package ras_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes of the return-address stack
  //////////////////////////////////////////////////////////////////////
  localparam int ras_threads   = 2;                 // Hardware threads sharing the RAM
  localparam int ras_depth     = 16;                // Entries per thread
  localparam int ras_ptr_w     = 4;                 // Per-thread pointer width
  localparam int ras_addr_w    = 5;                 // Thread bit plus pointer
  localparam int ras_va_w      = 47;                // Full return address width
  localparam int ras_slot_w    = 4;                 // Slot within a bundle
  localparam int ras_bundle_w  = ras_va_w - ras_slot_w;  // Bundle address width
  localparam int ras_far_off_w = 12;                // Signed bundle offset of far calls

  // Pointer value of an empty stack
  localparam logic [ras_ptr_w-1:0] ras_ptr_top = ras_ptr_w'(ras_depth - 1);

  // Opcode classes in opcode bits 7:6, bit 5 flags a far call
  localparam logic [1:0] ras_opc_call = 2'b10;
  localparam logic [1:0] ras_opc_ret  = 2'b11;

  //////////////////////////////////////////////////////////////////////
  // Shared packets
  //////////////////////////////////////////////////////////////////////
  typedef struct packed {
    logic                thread;
    logic [ras_va_w-1:0] pc;
    logic [7:0]          opcode;
    logic [15:0]         link_off;                  // Slot in 3:0, bundle offset above
  } fetch_pkt_t;

  typedef struct packed {
    logic                push;
    logic                pop;
    logic                thread;
    logic [ras_va_w-1:0] ret_addr;
  } stack_op_t;

  typedef struct packed {
    logic                thread;
    logic [ras_va_w-1:0] target;
  } ras_pred_t;

endpackage

`default_nettype wire

// File: design/ras_ram.sv
// Storage has no reset and reads undefined until written; read data follows the held address
`timescale 1ns/1ps
`default_nettype none

module ras_ram
  import ras_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  rd_en,
  input  logic [ras_addr_w-1:0] rd_addr,
  output logic [ras_va_w-1:0]   rd_data,
  input  logic                  wr_en,
  input  logic [ras_addr_w-1:0] wr_addr,
  input  logic [ras_va_w-1:0]   wr_data
);

  logic [ras_va_w-1:0]   mem [ras_threads*ras_depth];  // One bank per thread, thread is the MSB
  logic [ras_addr_w-1:0] rd_addr_q;                    // Address latched by the last read

  //////////////////////////////////////////////////////////////////////
  // Read port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_addr_q <= '0;
    end else if (rd_en) begin
      rd_addr_q <= rd_addr;  // Hold the address until the next read
    end
  end

  // An entry written after the read strobe still shows up here
  assign rd_data = mem[rd_addr_q];

  //////////////////////////////////////////////////////////////////////
  // Write port
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

// File: design/ras_branch_class.sv
// Purely combinational; push and pop are valid only in the cycle of fetch_valid
`timescale 1ns/1ps
`default_nettype none

module ras_branch_class
  import ras_pkg::*;
(
  input  logic       fetch_valid,
  input  fetch_pkt_t fetch,
  output stack_op_t  op
);

  logic [1:0]               opc_class;   // Opcode bits 7:6
  logic                     far_call;    // Opcode bit 5
  logic                     is_call;
  logic                     is_ret;
  logic [ras_far_off_w-1:0] far_off;     // Signed bundle distance of a far call
  logic                     near_next;   // Near call returns into the next bundle
  logic [ras_bundle_w-1:0]  far_ext;
  logic [ras_bundle_w-1:0]  near_ext;
  logic [ras_bundle_w-1:0]  bundle_off;
  logic [ras_bundle_w-1:0]  pc_bundle;
  logic [ras_bundle_w-1:0]  ret_bundle;
  logic [ras_slot_w-1:0]    ret_slot;

  //////////////////////////////////////////////////////////////////////
  // Opcode decode
  //////////////////////////////////////////////////////////////////////
  assign opc_class = fetch.opcode[7:6];
  assign far_call  = fetch.opcode[5];

  assign is_call = (opc_class == ras_opc_call);  // Any other class leaves the stack alone
  assign is_ret  = (opc_class == ras_opc_ret);

  //////////////////////////////////////////////////////////////////////
  // Return address
  //////////////////////////////////////////////////////////////////////
  assign far_off   = fetch.link_off[15:4];
  assign near_next = fetch.link_off[4];

  // Far offset is sign extended to the full bundle width
  assign far_ext  = {{(ras_bundle_w - ras_far_off_w){far_off[ras_far_off_w-1]}}, far_off};
  assign near_ext = {{(ras_bundle_w - 1){1'b0}}, near_next};

  assign bundle_off = far_call ? far_ext : near_ext;

  assign pc_bundle  = fetch.pc[ras_va_w-1:ras_slot_w];
  assign ret_bundle = pc_bundle + bundle_off;      // Wraps at the top of the address space
  assign ret_slot   = fetch.link_off[ras_slot_w-1:0];

  //////////////////////////////////////////////////////////////////////
  // Stack operation
  //////////////////////////////////////////////////////////////////////
  // Opcode classes are exclusive, so push and pop never fire together
  assign op.push     = fetch_valid & is_call;
  assign op.pop      = fetch_valid & is_ret;
  assign op.thread   = fetch.thread;
  assign op.ret_addr = {ret_bundle, ret_slot};     // Only meaningful for a push

endmodule

`default_nettype wire

// File: design/ras_stack.sv
// Stack wraps silently at 16 entries; a flush drops the fetch of its cycle and the pending push
`timescale 1ns/1ps
`default_nettype none

module ras_stack
  import ras_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  stack_op_t op,
  input  logic      flush_valid,
  input  logic      flush_thread,
  output logic      pred_valid,
  output ras_pred_t pred
);

  // Push waiting for its RAM write one cycle later
  typedef struct packed {
    logic                 thread;
    logic [ras_ptr_w-1:0] ptr;
    logic [ras_va_w-1:0]  data;
  } pend_wr_t;

  logic [ras_ptr_w-1:0]  rd_ptr [ras_threads];  // Top of stack per thread
  logic [ras_ptr_w-1:0]  wr_ptr [ras_threads];  // Next free slot per thread
  logic                  do_push;
  logic                  do_pop;
  logic                  pend_en;
  pend_wr_t              pend;
  logic                  byp_hit;
  logic [ras_va_w-1:0]   byp_data;
  logic                  pop_thread;
  logic                  ram_rd_en;
  logic [ras_addr_w-1:0] ram_rd_addr;
  logic [ras_va_w-1:0]   ram_rd_data;
  logic                  ram_wr_en;
  logic [ras_addr_w-1:0] ram_wr_addr;

  // A flush wins over any fetch in the same cycle
  assign do_push = op.push & ~flush_valid;
  assign do_pop  = op.pop & ~flush_valid;

  //////////////////////////////////////////////////////////////////////
  // Pointers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int t = 0; t < ras_threads; t++) begin
        rd_ptr[t] <= ras_ptr_top;
        wr_ptr[t] <= '0;
      end
    end else if (flush_valid) begin
      rd_ptr[flush_thread] <= ras_ptr_top;  // Other thread keeps its stack
      wr_ptr[flush_thread] <= '0;
    end else if (do_push) begin
      rd_ptr[op.thread] <= rd_ptr[op.thread] + ras_ptr_w'(1);
      wr_ptr[op.thread] <= wr_ptr[op.thread] + ras_ptr_w'(1);
    end else if (do_pop) begin
      rd_ptr[op.thread] <= rd_ptr[op.thread] - ras_ptr_w'(1);
      wr_ptr[op.thread] <= wr_ptr[op.thread] - ras_ptr_w'(1);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Delayed write stage
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      pend_en <= 1'b0;
    end else begin
      pend_en <= do_push;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      pend.thread <= op.thread;
      pend.ptr    <= wr_ptr[op.thread];  // Slot before the increment
      pend.data   <= op.ret_addr;
    end
  end

  // A flush in the write cycle cancels the push of the cycle before, on either thread
  assign ram_wr_en   = pend_en & ~flush_valid;
  assign ram_wr_addr = {pend.thread, pend.ptr};

  //////////////////////////////////////////////////////////////////////
  // Read and prediction
  //////////////////////////////////////////////////////////////////////
  assign ram_rd_en   = do_pop;
  assign ram_rd_addr = {op.thread, rd_ptr[op.thread]};

  always_ff @(posedge clk) begin
    if (rst) begin
      pred_valid <= 1'b0;
      byp_hit    <= 1'b0;
    end else begin
      pred_valid <= do_pop;
      // Pop right behind a push of its own thread takes the pending data
      byp_hit    <= do_pop & ram_wr_en & (pend.thread == op.thread);
    end
  end

  always_ff @(posedge clk) begin
    if (do_pop) begin
      pop_thread <= op.thread;
      byp_data   <= pend.data;
    end
  end

  assign pred.thread = pop_thread;
  assign pred.target = byp_hit ? byp_data : ram_rd_data;

  ras_ram u_ram (
    .clk     (clk),
    .rst     (rst),
    .rd_en   (ram_rd_en),
    .rd_addr (ram_rd_addr),
    .rd_data (ram_rd_data),
    .wr_en   (ram_wr_en),
    .wr_addr (ram_wr_addr),
    .wr_data (pend.data)
  );

endmodule

`default_nettype wire

// File: design/ras_predictor.sv
// Inputs are one-cycle strobes with no stall; pred_valid follows a return by one clock
`timescale 1ns/1ps
`default_nettype none

module ras_predictor
  import ras_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // Fetch side
  input  logic       fetch_valid,
  input  fetch_pkt_t fetch,

  // Pipeline flush of one thread
  input  logic       flush_valid,
  input  logic       flush_thread,

  // Predicted return target
  output logic       pred_valid,
  output ras_pred_t  pred
);

  stack_op_t op;  // Decoded push or pop of this cycle

  //////////////////////////////////////////////////////////////////////
  // Classifier
  //////////////////////////////////////////////////////////////////////
  // Turns the fetched opcode into a stack operation in the same cycle
  ras_branch_class u_class (
    .fetch_valid (fetch_valid),
    .fetch       (fetch),
    .op          (op)
  );

  //////////////////////////////////////////////////////////////////////
  // Stack with its RAM
  //////////////////////////////////////////////////////////////////////
  // Pointers, delayed write and the registered prediction live here
  ras_stack u_stack (
    .clk          (clk),
    .rst          (rst),
    .op           (op),
    .flush_valid  (flush_valid),
    .flush_thread (flush_thread),
    .pred_valid   (pred_valid),
    .pred         (pred)
  );

endmodule

`default_nettype wire

// File: tests/tb_clk_gen.sv
// Clock starts low at time zero; rst is released 1 ns after the third rising edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;  // 100 ns period
  end

  initial begin
    rst = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst = 1'b0;           // Released off the edge like the other inputs
  end

endmodule

`default_nettype wire

// File: include/ras_tests.svh
// Tests share the DUT state and must run in the order the testbench top calls them
`ifndef ras_tests_svh
`define ras_tests_svh

//////////////////////////////////////////////////////////////////////
// Reset, then near and far calls unwound in LIFO order
//////////////////////////////////////////////////////////////////////
task automatic test_lifo();
  idle_cycles(5);                    // No prediction may appear here
  send_call(1'b0, 1'b0, 16'h0013);
  send_call(1'b0, 1'b1, 16'h0248);
  send_call(1'b0, 1'b0, 16'h0002);
  idle_cycles(1);
  repeat (3) send_ret(1'b0);
  drain_predictions();
endtask

task automatic test_offsets();
  int r;
  send_call(1'b0, 1'b1, 16'hffd5);  // Three bundles back, slot 5
  send_call(1'b0, 1'b1, 16'h8007);  // Largest backward distance
  send_call(1'b0, 1'b0, 16'habf1);  // Near call into the next bundle
  send_call(1'b0, 1'b0, 16'habe9);  // Near call in the same bundle
  for (int i = 0; i < 6; i++) begin
    r = $random(seed);
    send_call(1'b0, r[8], r[31:16]);
  end
  repeat (10) send_ret(1'b0);
  drain_predictions();
endtask

//////////////////////////////////////////////////////////////////////
// Bypass and two independent stacks
//////////////////////////////////////////////////////////////////////
task automatic test_bypass();
  send_call(1'b1, 1'b0, 16'h0011);
  send_ret(1'b1);                    // Served from the pending write
  send_call(1'b0, 1'b1, 16'h0104);
  send_call(1'b1, 1'b0, 16'h000e);
  send_call(1'b0, 1'b0, 16'h0019);
  send_ret(1'b1);                    // Other thread pushed last, so this reads the RAM
  send_ret(1'b0);
  send_call(1'b1, 1'b1, 16'hfe03);
  send_ret(1'b1);
  send_ret(1'b0);
  drain_predictions();
endtask

task automatic test_wrap();
  int r;
  for (int i = 0; i < 18; i++) begin
    r = $random(seed);
    send_call(1'b0, r[3], r[31:16]);
  end
  repeat (16) send_ret(1'b0);        // Oldest two were overwritten
  drain_predictions();
endtask

//////////////////////////////////////////////////////////////////////
// Flush and non-branch fetches
//////////////////////////////////////////////////////////////////////
task automatic test_flush();
  send_call(1'b1, 1'b0, 16'h0021);
  send_call(1'b1, 1'b1, 16'h0036);
  send_ret(1'b1);
  send_call(1'b1, 1'b0, 16'h0017);  // Write is cancelled by the flush below
  apply_cycle(1'b1, make_pkt(1'b1, ras_opc_call, 1'b1, 16'h0ff9), 1'b1, 1'b0);
  send_ret(1'b1);                    // Slot still holds the older address
  send_ret(1'b1);
  send_ret(1'b0);                    // Thread 0 restarts from the top slot
  send_call(1'b0, 1'b0, 16'h001c);
  idle_cycles(1);
  send_ret(1'b0);
  drain_predictions();
endtask

task automatic test_non_branch();
  int r;
  send_call(1'b0, 1'b1, 16'h7ff2);
  send_call(1'b1, 1'b0, 16'h0005);
  for (int i = 0; i < 8; i++) begin
    r = $random(seed);
    apply_cycle(1'b1, make_pkt(i[0], {1'b0, r[0]}, r[1], r[31:16]), 1'b0, 1'b0);
  end
  send_ret(1'b1);
  send_ret(1'b0);
  drain_predictions();
endtask

`endif

// File: tests/tb_ras_predictor.sv
// Directed tests run in a fixed order; later tests rely on RAM slots filled by earlier ones
`timescale 1ns/1ps
`default_nettype none

module tb_ras_predictor
  import ras_pkg::*;
();

  logic       clk;
  logic       rst;
  logic       fetch_valid;
  fetch_pkt_t fetch;
  logic       flush_valid;
  logic       flush_thread;
  logic       pred_valid;
  ras_pred_t  pred;

  // Reference model of both stacks where writes land at the push
  logic [ras_va_w-1:0]  m_mem [ras_threads][ras_depth];
  logic                 m_ok  [ras_threads][ras_depth];  // Slot holds a known address
  logic [ras_ptr_w-1:0] m_wp  [ras_threads];
  logic                 pend_on;                         // Push of the previous cycle
  logic                 pend_thread;
  logic [ras_ptr_w-1:0] pend_slot;
  logic [ras_va_w-1:0]  pend_old;                        // Slot contents before that push
  logic                 pend_old_ok;
  logic                 ret_last_cycle;                  // Prediction is due in this cycle
  ras_pred_t            exp_q [$];                       // Predictions still to come
  int                   err_count;
  int                   fail_count;
  int                   seed;

  tb_clk_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  ras_predictor u_dut (
    .clk          (clk),
    .rst          (rst),
    .fetch_valid  (fetch_valid),
    .fetch        (fetch),
    .flush_valid  (flush_valid),
    .flush_thread (flush_thread),
    .pred_valid   (pred_valid),
    .pred         (pred)
  );

  ////////////////////////////////////////////////////////////////////
  // Checking
  ////////////////////////////////////////////////////////////////////
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    if (expected !== actual) begin
      err_count++;
      $display("ERR %0t %s expected %h actual %h", $time, name, expected, actual);
    end
  endtask

  // Called once per cycle, before the new inputs are driven
  task automatic sample_outputs();
    ras_pred_t want;
    if (pred_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        fail_count++;
        $display("Prediction at %0t on thread %0d was not expected", $time, pred.thread);
      end else begin
        if (!ret_last_cycle) begin
          fail_count++;
          $display("Prediction at %0t came later than one cycle after its return", $time);
        end
        want = exp_q.pop_front();
        check_value("pred.thread", 64'(want.thread), 64'(pred.thread));
        check_value("pred.target", 64'(want.target), 64'(pred.target));
      end
    end else if (pred_valid !== 1'b0) begin
      fail_count++;
      $display("pred_valid is unknown at %0t", $time);
    end
    if (ret_last_cycle && pred_valid !== 1'b1) begin
      fail_count++;
      $display("No prediction at %0t for the return of the previous cycle", $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////
  function automatic logic [ras_va_w-1:0] expect_ret_addr(input fetch_pkt_t pkt);
    logic [ras_bundle_w-1:0] base;
    logic [ras_bundle_w-1:0] step;
    base = pkt.pc[ras_va_w-1:4];
    if (pkt.opcode[5]) begin
      step = {{31{pkt.link_off[15]}}, pkt.link_off[15:4]};  // Signed bundle distance
    end else begin
      step = {42'd0, pkt.link_off[4]};
    end
    return {base + step, pkt.link_off[3:0]};
  endfunction

  task automatic model_cycle(input logic fv, input fetch_pkt_t pkt, input logic flv,
                             input logic flt);
    logic                 t;
    logic [ras_ptr_w-1:0] slot;
    ras_pred_t            want;
    t = pkt.thread;
    ret_last_cycle = 1'b0;
    if (flv && pend_on) begin
      m_mem[pend_thread][pend_slot] = pend_old;  // Write never reaches the RAM
      m_ok[pend_thread][pend_slot]  = pend_old_ok;
    end
    pend_on = 1'b0;
    if (flv) begin
      m_wp[flt] = '0;
    end else if (fv && pkt.opcode[7:6] == ras_opc_call) begin
      slot        = m_wp[t];
      pend_on     = 1'b1;
      pend_thread = t;
      pend_slot   = slot;
      pend_old    = m_mem[t][slot];
      pend_old_ok = m_ok[t][slot];
      m_mem[t][slot] = expect_ret_addr(pkt);
      m_ok[t][slot]  = 1'b1;
      m_wp[t]        = slot + ras_ptr_w'(1);
    end else if (fv && pkt.opcode[7:6] == ras_opc_ret) begin
      slot = m_wp[t] - ras_ptr_w'(1);
      if (!m_ok[t][slot]) begin
        fail_count++;
        $display("Return at %0t reads a slot of thread %0d never written", $time, t);
      end
      want.thread = t;
      want.target = m_mem[t][slot];
      exp_q.push_back(want);
      m_wp[t] = slot;
      ret_last_cycle = 1'b1;
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////
  function automatic fetch_pkt_t make_pkt(input logic t, input logic [1:0] cls,
                                          input logic far, input logic [15:0] link_off);
    fetch_pkt_t  pkt;
    logic [63:0] r;
    r = {$random(seed), $random(seed)};
    pkt.thread   = t;
    pkt.pc       = r[ras_va_w-1:0];
    pkt.opcode   = {cls, far, r[51:47]};  // Low opcode bits are don't care
    pkt.link_off = link_off;
    return pkt;
  endfunction

  // One clock of stimulus, entered and left 1 ns after a rising edge
  task automatic apply_cycle(input logic fv, input fetch_pkt_t pkt, input logic flv,
                             input logic flt);
    sample_outputs();
    fetch_valid  = fv;
    fetch        = pkt;
    flush_valid  = flv;
    flush_thread = flt;
    model_cycle(fv, pkt, flv, flt);
    @(posedge clk);
    #1;
  endtask

  // Calls and returns sit on the bus with fetch_valid low
  task automatic idle_cycles(input int n);
    for (int i = 0; i < n; i++) begin
      apply_cycle(1'b0, make_pkt(i[0], i[1] ? ras_opc_call : ras_opc_ret, 1'b0, 16'h0000),
                  1'b0, 1'b0);
    end
  endtask

  task automatic send_call(input logic t, input logic far, input logic [15:0] link_off);
    apply_cycle(1'b1, make_pkt(t, ras_opc_call, far, link_off), 1'b0, 1'b0);
  endtask

  task automatic send_ret(input logic t);
    apply_cycle(1'b1, make_pkt(t, ras_opc_ret, 1'b0, 16'($random(seed))), 1'b0, 1'b0);
  endtask

  task automatic drain_predictions();
    int cycles;
    cycles = 0;
    while (exp_q.size() != 0 && cycles < 20) begin
      idle_cycles(1);
      cycles++;
    end
    if (exp_q.size() != 0) begin
      fail_count++;
      $display("Timed out at %0t waiting for pred_valid with %0d predictions missing",
               $time, exp_q.size());
      exp_q.delete();
    end
  endtask

  task automatic wait_reset();
    int cycles;
    cycles = 0;
    while (rst !== 1'b0 && cycles < 20) begin
      @(posedge clk);
      cycles++;
    end
    if (rst !== 1'b0) begin
      fail_count++;
      $display("Reset was never released");
    end
    @(posedge clk);
    #1;
  endtask

  `include "ras_tests.svh"

  initial begin
    seed           = 32'h7caa;
    err_count      = 0;
    fail_count     = 0;
    fetch_valid    = 1'b0;
    fetch          = '0;
    flush_valid    = 1'b0;
    flush_thread   = 1'b0;
    pend_on        = 1'b0;
    ret_last_cycle = 1'b0;
    for (int t = 0; t < ras_threads; t++) begin
      m_wp[t] = '0;
      for (int i = 0; i < ras_depth; i++) begin
        m_ok[t][i] = 1'b0;
      end
    end
    wait_reset();
    test_lifo();
    test_offsets();
    test_bypass();
    test_wrap();
    test_flush();
    test_non_branch();
    $display("Done with %0d value errors and %0d other failures", err_count, fail_count);
    if (err_count == 0 && fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
+incdir+include
design/ras_pkg.sv
design/ras_ram.sv
design/ras_branch_class.sv
design/ras_stack.sv
design/ras_predictor.sv
tests/tb_clk_gen.sv
tests/tb_ras_predictor.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 --top-module tb_ras_predictor -f src.f \
  -o tb_ras_predictor

./obj_dir/tb_ras_predictor > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Run reported failure, see sim.log"
  exit 1
fi
exit 0
